// File: hdl/tile_defs.svh
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// datapath and register widths
`define TILE_XLEN        32
`define TILE_RF_AW       5
`define TILE_RING_ID_W   5

// instruction memory, word addressed
`define TILE_IMEM_AW     6
`define TILE_IMEM_DEPTH  64

// kept rv32i opcodes
`define TILE_OP_IMM      7'b0010011
`define TILE_OP_REG      7'b0110011
`define TILE_OP_STORE    7'b0100011

// addi x0, x0, 0
`define TILE_NOP         32'h0000_0013

// ring command codes
`define TILE_NET_PC      2'd0
`define TILE_NET_INSTR   2'd1
`define TILE_NET_REG     2'd2
`define TILE_NET_NONE    2'd3

`endif

// File: hdl/tile_pkg.sv
`include "tile_defs.svh"

package tile_pkg;

   //////////////////////////////
   // network and core state
   //////////////////////////////

   // what a ring packet asks the tile to do
   typedef enum logic [1:0]
   {
      NET_PC    = `TILE_NET_PC,
      NET_INSTR = `TILE_NET_INSTR,
      NET_REG   = `TILE_NET_REG,
      NET_NONE  = `TILE_NET_NONE
   } net_op_e;

   // idle until the network loads a pc
   typedef enum logic
   {
      IDLE = 1'b0,
      RUN  = 1'b1
   } core_state_e;

   //////////////////////////////
   // decode and shared requests
   //////////////////////////////

   // control for the instruction sitting in execute
   typedef struct packed
   {
      logic valid_op;
      logic writes_rf;
      logic is_store;
      logic is_byte;
      logic is_hex;
      logic use_imm;
      logic is_sub;
   } decode_s;

   // one imem access, network write or fetch read
   typedef struct packed
   {
      logic                     en;
      logic                     we;
      logic [`TILE_IMEM_AW-1:0] addr;
      logic [`TILE_XLEN-1:0]    data;
   } imem_req_s;

   // one register write, network or writeback
   typedef struct packed
   {
      logic [`TILE_RF_AW-1:0] addr;
      logic [`TILE_XLEN-1:0]  data;
   } rf_wr_s;

endpackage

// File: hdl/net_priority_arb.sv
module net_priority_arb
#(
   parameter type payload_t = logic
)
(
   input  logic     hi_valid_i,
   input  payload_t hi_payload_i,
   input  logic     lo_valid_i,
   input  payload_t lo_payload_i,
   output logic     out_valid_o,
   output payload_t out_payload_o,
   output logic     lo_grant_o
);

   // network side always wins the shared port
   assign out_valid_o   = hi_valid_i | lo_valid_i;
   assign out_payload_o = hi_valid_i ? hi_payload_i : lo_payload_i;

   // low side is served whenever the network is quiet
   // (independent of lo_valid_i so the pipeline can use it for stall)
   assign lo_grant_o    = ~hi_valid_i;

endmodule

// File: hdl/net_cmd_decoder.sv
`include "tile_defs.svh"

module net_cmd_decoder
#(
   parameter logic [`TILE_RING_ID_W-1:0] ring_id_p = '0
)
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        net_valid_i,
   input  logic [`TILE_RING_ID_W-1:0]  net_ring_id_i,
   input  logic                        net_external_i,
   input  logic                        net_bc_i,
   input  tile_pkg::net_op_e           net_op_i,
   input  logic [`TILE_XLEN-1:0]       net_addr_i,
   input  logic [`TILE_XLEN-1:0]       net_data_i,
   output logic                        imem_wr_valid_o,
   output tile_pkg::imem_req_s         imem_wr_o,
   output logic                        rf_wr_valid_o,
   output tile_pkg::rf_wr_s            rf_wr_o,
   output logic                        pc_load_o,
   output logic [`TILE_IMEM_AW-1:0]    pc_load_addr_o,
   output tile_pkg::core_state_e       state_o
);

   //////////////////////////////
   // packet register
   //////////////////////////////

   logic                        valid_r;
   logic [`TILE_RING_ID_W-1:0]  ring_id_r;
   logic                        external_r;
   logic                        bc_r;
   tile_pkg::net_op_e           op_r;
   logic [`TILE_XLEN-1:0]       addr_r;
   logic [`TILE_XLEN-1:0]       data_r;
   logic                        exec_pkt;
   tile_pkg::core_state_e       state_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_r <= 1'b0;
      end
      else
      begin
         valid_r <= net_valid_i;
      end
   end

   // header and data only matter when valid_r is set
   always_ff @(posedge clk)
   begin
      ring_id_r  <= net_ring_id_i;
      external_r <= net_external_i;
      bc_r       <= net_bc_i;
      op_r       <= net_op_i;
      addr_r     <= net_addr_i;
      data_r     <= net_data_i;
   end

   //////////////////////////////
   // filter and command strobes
   //////////////////////////////

   // take it if addressed to us and not a broadcast,
   // or a broadcast that some other core sent
   assign exec_pkt = valid_r & ~external_r & ((ring_id_r == ring_id_p) ^ bc_r);

   assign imem_wr_valid_o = exec_pkt & (op_r == tile_pkg::NET_INSTR);
   assign imem_wr_o       = '{en: 1'b1, we: 1'b1, addr: addr_r[2 +: `TILE_IMEM_AW],
                              data: data_r};

   // register number sits in the low address bits
   assign rf_wr_valid_o = exec_pkt & (op_r == tile_pkg::NET_REG);
   assign rf_wr_o       = '{addr: addr_r[`TILE_RF_AW-1:0], data: data_r};

   // pc load only counts while idle
   assign pc_load_o      = exec_pkt & (op_r == tile_pkg::NET_PC) & (state_r == tile_pkg::IDLE);
   assign pc_load_addr_o = addr_r[2 +: `TILE_IMEM_AW];

   // idle -> run on pc load, no way back short of reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_r <= tile_pkg::IDLE;
      end
      else if (pc_load_o)
      begin
         state_r <= tile_pkg::RUN;
      end
   end

   assign state_o = state_r;

endmodule

// File: hdl/imem.sv
`include "tile_defs.svh"

module imem
(
   input  logic                   clk,
   input  logic                   req_valid_i,
   input  tile_pkg::imem_req_s    req_i,
   output logic [`TILE_XLEN-1:0]  rdata_o
);

   // 64 x 32 single port array
   logic [`TILE_XLEN-1:0] mem_r [`TILE_IMEM_DEPTH];

   // one access per cycle, write or read
   always_ff @(posedge clk)
   begin
      if (req_valid_i & req_i.en)
      begin
         if (req_i.we)
         begin
            mem_r[req_i.addr] <= req_i.data;
         end
         else
         begin
            // read word shows up after the edge
            rdata_o <= mem_r[req_i.addr];
         end
      end
   end

endmodule

// File: hdl/regfile.sv
`include "tile_defs.svh"

module regfile
(
   input  logic                   clk,
   input  logic                   wr_valid_i,
   input  tile_pkg::rf_wr_s       wr_i,
   input  logic [`TILE_RF_AW-1:0] rs1_addr_i,
   input  logic [`TILE_RF_AW-1:0] rs2_addr_i,
   output logic [`TILE_XLEN-1:0]  rs1_data_o,
   output logic [`TILE_XLEN-1:0]  rs2_data_o
);

   logic [`TILE_XLEN-1:0] rf_r [2**`TILE_RF_AW];

   // x0 never gets written
   always_ff @(posedge clk)
   begin
      if (wr_valid_i & (wr_i.addr != '0))
      begin
         rf_r[wr_i.addr] <= wr_i.data;
      end
   end

   // async reads, x0 forced to zero
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf_r[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf_r[rs2_addr_i];

endmodule

// File: hdl/fetch_unit.sv
`include "tile_defs.svh"

module fetch_unit
(
   input  logic                      clk,
   input  logic                      reset,
   input  tile_pkg::core_state_e     state_i,
   input  logic                      pc_load_i,
   input  logic [`TILE_IMEM_AW-1:0]  pc_load_addr_i,
   input  logic                      grant_i,
   input  logic                      stall_i,
   input  logic [`TILE_XLEN-1:0]     rdata_i,
   output logic                      rd_valid_o,
   output tile_pkg::imem_req_s       rd_req_o,
   output logic [`TILE_XLEN-1:0]     instr_o
);

   logic [`TILE_IMEM_AW-1:0] pc_r;
   logic [`TILE_IMEM_AW-1:0] pc_n;
   logic                     pc_wen;
   logic                     fetched_r;
   logic [`TILE_XLEN-1:0]    hold_r;

   //////////////////////////////
   // pc
   //////////////////////////////

   // network load wins, otherwise step one word and wrap
   assign pc_n = pc_load_i ? pc_load_addr_i : pc_r + 1'b1;

   // move only when running and nothing holds us
   assign pc_wen = pc_load_i | ((state_i == tile_pkg::RUN) & ~stall_i & grant_i);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc_r <= '0;
      end
      else if (pc_wen)
      begin
         pc_r <= pc_n;
      end
   end

   // read the next pc so its word lines up with pc_r
   assign rd_valid_o = pc_wen;
   assign rd_req_o   = '{en: pc_wen, we: 1'b0, addr: pc_n, data: '0};

   //////////////////////////////
   // instruction hold
   //////////////////////////////

   // remember whether last edge actually read imem
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fetched_r <= 1'b0;
         hold_r    <= `TILE_NOP;
      end
      else
      begin
         fetched_r <= rd_valid_o & grant_i;
         hold_r    <= instr_o;
      end
   end

   // fresh word after a read, else replay what we showed last cycle
   assign instr_o = fetched_r ? rdata_i : hold_r;

endmodule

// File: hdl/exec_unit.sv
`include "tile_defs.svh"

module exec_unit
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`TILE_XLEN-1:0]   instr_i,
   input  logic [`TILE_XLEN-1:0]   rs1_data_i,
   input  logic [`TILE_XLEN-1:0]   rs2_data_i,
   input  logic                    rf_grant_i,
   input  logic                    imem_grant_i,
   input  logic                    mem_yumi_i,
   output logic [`TILE_RF_AW-1:0]  rs1_addr_o,
   output logic [`TILE_RF_AW-1:0]  rs2_addr_o,
   output logic                    rf_wr_valid_o,
   output tile_pkg::rf_wr_s        rf_wr_o,
   output logic                    stall_o,
   output logic                    mem_valid_o,
   output logic [`TILE_XLEN-1:0]   mem_addr_o,
   output logic [`TILE_XLEN-1:0]   mem_data_o,
   output logic [3:0]              mem_mask_o
);

   logic [`TILE_XLEN-1:0] instr_r;
   tile_pkg::decode_s     dec;
   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic [`TILE_XLEN-1:0] imm_i;
   logic [`TILE_XLEN-1:0] imm_s;
   logic [`TILE_XLEN-1:0] op_b;
   logic [`TILE_XLEN-1:0] result;
   logic [1:0]            lane;
   logic                  store_wait;

   //////////////////////////////
   // execute register
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         instr_r <= `TILE_NOP;
      end
      else if (~stall_o)
      begin
         instr_r <= instr_i;
      end
   end

   //////////////////////////////
   // decode
   //////////////////////////////

   assign opcode = instr_r[6:0];
   assign funct3 = instr_r[14:12];
   assign funct7 = instr_r[31:25];

   // anything not listed stays all zero and acts as a no-op
   always_comb
   begin
      dec = '0;
      case (opcode)
         `TILE_OP_IMM:
         begin
            // addi only
            if (funct3 == 3'b000)
            begin
               dec.valid_op  = 1'b1;
               dec.writes_rf = 1'b1;
               dec.use_imm   = 1'b1;
            end
         end
         `TILE_OP_REG:
         begin
            // add / sub
            if ((funct3 == 3'b000) & ((funct7 == 7'b0000000) | (funct7 == 7'b0100000)))
            begin
               dec.valid_op  = 1'b1;
               dec.writes_rf = 1'b1;
               dec.is_sub    = funct7[5];
            end
         end
         `TILE_OP_STORE:
         begin
            // sb, sh, sw
            if ((funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010))
            begin
               dec.valid_op = 1'b1;
               dec.is_store = 1'b1;
               dec.is_byte  = (funct3 == 3'b000);
               dec.is_hex   = (funct3 == 3'b001);
            end
         end
         default:
         begin
            dec = '0;
         end
      endcase
   end

   assign rs1_addr_o = instr_r[19:15];
   assign rs2_addr_o = instr_r[24:20];

   //////////////////////////////
   // alu and writeback
   //////////////////////////////

   assign imm_i = {{20{instr_r[31]}}, instr_r[31:20]};
   assign imm_s = {{20{instr_r[31]}}, instr_r[31:25], instr_r[11:7]};

   assign op_b   = dec.use_imm ? imm_i : rs2_data_i;
   assign result = dec.is_sub ? rs1_data_i - op_b : rs1_data_i + op_b;

   // write once, on the edge that lets this instruction leave
   assign rf_wr_valid_o = dec.valid_op & dec.writes_rf & ~stall_o;
   assign rf_wr_o       = '{addr: instr_r[11:7], data: result};

   //////////////////////////////
   // store path
   //////////////////////////////

   assign mem_addr_o = rs1_data_i + imm_s;
   assign lane       = mem_addr_o[1:0];

   // place byte / half in its lane
   always_comb
   begin
      if (dec.is_byte)
      begin
         mem_data_o = {24'b0, rs2_data_i[7:0]} << {lane, 3'b000};
         mem_mask_o = 4'b0001 << lane;
      end
      else if (dec.is_hex)
      begin
         mem_data_o = {16'b0, rs2_data_i[15:0]} << {lane, 3'b000};
         mem_mask_o = 4'b0011 << lane;
      end
      else
      begin
         mem_data_o = rs2_data_i;
         mem_mask_o = 4'b1111;
      end
   end

   // valid drops while the network owns a shared port
   assign mem_valid_o = dec.valid_op & dec.is_store & rf_grant_i & imem_grant_i;
   assign store_wait  = mem_valid_o & ~mem_yumi_i;

   // hold whole pipe on a pending store or a lost arbitration
   assign stall_o = store_wait | ~rf_grant_i | ~imem_grant_i;

endmodule

// File: hdl/tile_core.sv
`include "tile_defs.svh"

module tile_core
#(
   parameter logic [`TILE_RING_ID_W-1:0] ring_id_p = '0
)
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        net_valid_i,
   input  logic [`TILE_RING_ID_W-1:0]  net_ring_id_i,
   input  logic                        net_external_i,
   input  logic                        net_bc_i,
   input  tile_pkg::net_op_e           net_op_i,
   input  logic [`TILE_XLEN-1:0]       net_addr_i,
   input  logic [`TILE_XLEN-1:0]       net_data_i,
   output logic                        mem_valid_o,
   output logic [`TILE_XLEN-1:0]       mem_addr_o,
   output logic [`TILE_XLEN-1:0]       mem_data_o,
   output logic [3:0]                  mem_mask_o,
   input  logic                        mem_yumi_i
);

   // imem path
   logic                     net_imem_valid;
   tile_pkg::imem_req_s      net_imem_req;
   logic                     fetch_rd_valid;
   tile_pkg::imem_req_s      fetch_rd_req;
   logic                     imem_valid;
   tile_pkg::imem_req_s      imem_req;
   logic                     imem_grant;
   logic [`TILE_XLEN-1:0]    imem_rdata;
   // register file path
   logic                     net_rf_valid;
   tile_pkg::rf_wr_s         net_rf_wr;
   logic                     ex_rf_valid;
   tile_pkg::rf_wr_s         ex_rf_wr;
   logic                     rf_valid;
   tile_pkg::rf_wr_s         rf_wr;
   logic                     rf_grant;
   logic [`TILE_RF_AW-1:0]   rs1_addr;
   logic [`TILE_RF_AW-1:0]   rs2_addr;
   logic [`TILE_XLEN-1:0]    rs1_data;
   logic [`TILE_XLEN-1:0]    rs2_data;
   // control
   logic                     pc_load;
   logic [`TILE_IMEM_AW-1:0] pc_load_addr;
   tile_pkg::core_state_e    state;
   logic [`TILE_XLEN-1:0]    instr;
   logic                     stall;

   //////////////////////////////
   // network side
   //////////////////////////////

   net_cmd_decoder #(.ring_id_p(ring_id_p)) net_cmd_decoder_i
   (
      .clk(clk), .reset(reset),
      .net_valid_i(net_valid_i), .net_ring_id_i(net_ring_id_i),
      .net_external_i(net_external_i), .net_bc_i(net_bc_i), .net_op_i(net_op_i),
      .net_addr_i(net_addr_i), .net_data_i(net_data_i),
      .imem_wr_valid_o(net_imem_valid), .imem_wr_o(net_imem_req),
      .rf_wr_valid_o(net_rf_valid), .rf_wr_o(net_rf_wr),
      .pc_load_o(pc_load), .pc_load_addr_o(pc_load_addr), .state_o(state)
   );

   //////////////////////////////
   // shared resources
   //////////////////////////////

   net_priority_arb #(.payload_t(tile_pkg::imem_req_s)) imem_arb_i
   (
      .hi_valid_i(net_imem_valid), .hi_payload_i(net_imem_req),
      .lo_valid_i(fetch_rd_valid), .lo_payload_i(fetch_rd_req),
      .out_valid_o(imem_valid), .out_payload_o(imem_req), .lo_grant_o(imem_grant)
   );

   net_priority_arb #(.payload_t(tile_pkg::rf_wr_s)) rf_arb_i
   (
      .hi_valid_i(net_rf_valid), .hi_payload_i(net_rf_wr),
      .lo_valid_i(ex_rf_valid), .lo_payload_i(ex_rf_wr),
      .out_valid_o(rf_valid), .out_payload_o(rf_wr), .lo_grant_o(rf_grant)
   );

   imem imem_i
   (
      .clk(clk), .req_valid_i(imem_valid), .req_i(imem_req), .rdata_o(imem_rdata)
   );

   regfile regfile_i
   (
      .clk(clk), .wr_valid_i(rf_valid), .wr_i(rf_wr),
      .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
   );

   //////////////////////////////
   // pipeline
   //////////////////////////////

   fetch_unit fetch_unit_i
   (
      .clk(clk), .reset(reset), .state_i(state),
      .pc_load_i(pc_load), .pc_load_addr_i(pc_load_addr),
      .grant_i(imem_grant), .stall_i(stall), .rdata_i(imem_rdata),
      .rd_valid_o(fetch_rd_valid), .rd_req_o(fetch_rd_req), .instr_o(instr)
   );

   exec_unit exec_unit_i
   (
      .clk(clk), .reset(reset), .instr_i(instr),
      .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .rf_grant_i(rf_grant), .imem_grant_i(imem_grant), .mem_yumi_i(mem_yumi_i),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
      .rf_wr_valid_o(ex_rf_valid), .rf_wr_o(ex_rf_wr), .stall_o(stall),
      .mem_valid_o(mem_valid_o), .mem_addr_o(mem_addr_o),
      .mem_data_o(mem_data_o), .mem_mask_o(mem_mask_o)
   );

endmodule

// File: test/tb_tile_core.sv
`include "tile_defs.svh"

module tb_tile_core;

   localparam int timeout_c = 2000;
   localparam int ring_id_c = 3;
   // main program sits at word 8, the short rerun program at word 0
   localparam int main_pc_c = 8;
   localparam int alt_pc_c  = 0;
   // shorter than the walk from the last main store to the wrap
   localparam int quiet_c   = 16;

   typedef struct packed
   {
      logic                        valid;
      logic [`TILE_RING_ID_W-1:0]  ring_id;
      logic                        external;
      logic                        bc;
      tile_pkg::net_op_e           op;
      logic [`TILE_XLEN-1:0]       addr;
      logic [`TILE_XLEN-1:0]       data;
   } pkt_t;

   logic                        clk;
   logic                        reset;
   logic                        net_valid_i;
   logic [`TILE_RING_ID_W-1:0]  net_ring_id_i;
   logic                        net_external_i;
   logic                        net_bc_i;
   tile_pkg::net_op_e           net_op_i;
   logic [`TILE_XLEN-1:0]       net_addr_i;
   logic [`TILE_XLEN-1:0]       net_data_i;
   logic                        mem_valid_o;
   logic [`TILE_XLEN-1:0]       mem_addr_o;
   logic [`TILE_XLEN-1:0]       mem_data_o;
   logic [3:0]                  mem_mask_o;
   logic                        mem_yumi_i;

   // packet table, model state and expected stores {addr, data, mask}
   pkt_t                  pkt_q[$];
   logic [`TILE_XLEN-1:0] model_imem [64];
   logic [`TILE_XLEN-1:0] model_rf [32];
   logic [67:0]           exp_q[$];
   int                    errors;
   int                    tests;
   int                    failed_tests;
   bit                    timed_out;

   tile_core #(.ring_id_p(ring_id_c)) dut_i
   (
      .clk(clk), .reset(reset),
      .net_valid_i(net_valid_i), .net_ring_id_i(net_ring_id_i),
      .net_external_i(net_external_i), .net_bc_i(net_bc_i), .net_op_i(net_op_i),
      .net_addr_i(net_addr_i), .net_data_i(net_data_i),
      .mem_valid_o(mem_valid_o), .mem_addr_o(mem_addr_o),
      .mem_data_o(mem_data_o), .mem_mask_o(mem_mask_o), .mem_yumi_i(mem_yumi_i)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // rv32i encoders
   //////////////////////////////

   function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `TILE_OP_IMM};
   endfunction

   function automatic logic [31:0] enc_reg(input int rd, input int rs1, input int rs2,
                                           input bit sub);
      return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `TILE_OP_REG};
   endfunction

   // sw rs2, imm(rs1) with f3 picking byte, half or word
   function automatic logic [31:0] enc_store(input int f3, input int rs2, input int rs1,
                                             input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `TILE_OP_STORE};
   endfunction

   //////////////////////////////
   // packet table
   //////////////////////////////

   function automatic void add_row(input logic v, input int ring, input logic ext,
                                   input logic bc, input tile_pkg::net_op_e op,
                                   input int addr, input logic [31:0] data);
      pkt_t p;
      p.valid    = v;
      p.ring_id  = ring[`TILE_RING_ID_W-1:0];
      p.external = ext;
      p.bc       = bc;
      p.op       = op;
      p.addr     = addr;
      p.data     = data;
      pkt_q.push_back(p);
   endfunction

   task automatic build_table();
      logic [31:0] prog [64];
      // padding no-ops carry their own word index
      for (int i = 0; i < 64; i++)
      begin
         prog[i]     = enc_addi(0, 0, i);
         model_rf[i % 32] = '0;
      end
      // rerun program
      prog[0]  = enc_store(2, 5, 0, 'h7f0);
      prog[1]  = enc_store(2, 4, 0, 'h7f4);
      // arithmetic chain and x0 targets
      prog[8]  = enc_addi(4, 1, 'h123);
      prog[9]  = enc_reg(5, 1, 2, 1'b0);
      prog[10] = enc_reg(6, 5, 3, 1'b1);
      prog[11] = enc_addi(7, 6, -7);
      prog[12] = enc_addi(0, 1, 5);
      prog[13] = enc_reg(0, 1, 2, 1'b0);
      prog[14] = enc_store(2, 4, 0, 'h100);
      prog[15] = enc_store(2, 5, 0, 'h104);
      prog[16] = enc_store(2, 6, 0, 'h108);
      prog[17] = enc_store(2, 7, 9, -4);
      prog[18] = enc_store(2, 0, 0, 'h110);
      // every byte lane and both half lanes
      prog[19] = enc_store(0, 1, 9, 0);
      prog[20] = enc_store(0, 2, 9, 1);
      prog[21] = enc_store(0, 3, 9, 2);
      prog[22] = enc_store(0, 4, 9, 3);
      prog[23] = enc_store(1, 5, 9, 4);
      prog[24] = enc_store(1, 6, 9, 6);
      // read back the filter targets
      for (int r = 10; r <= 14; r++)
      begin
         prog[25 + r - 10] = enc_store(2, r, 0, 'h300 + 4 * (r - 10));
      end
      for (int i = 0; i < 64; i++)
      begin
         add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_INSTR, i * 4, prog[i]);
      end
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 1, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 2, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 3, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 9, 32'h0000_1000);
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 0, $urandom());
      for (int r = 10; r <= 14; r++)
      begin
         add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, r, $urandom());
      end
      // other ring, external, own broadcast and idle slot are all dropped
      add_row(1'b1, 5, 1'b0, 1'b0, tile_pkg::NET_REG, 10, $urandom());
      add_row(1'b1, ring_id_c, 1'b1, 1'b0, tile_pkg::NET_REG, 11, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b1, tile_pkg::NET_REG, 12, $urandom());
      add_row(1'b0, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 10, $urandom());
      // broadcast from core 6 and a plain match both land
      add_row(1'b1, 6, 1'b0, 1'b1, tile_pkg::NET_REG, 13, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_REG, 14, $urandom());
      add_row(1'b1, ring_id_c, 1'b0, 1'b0, tile_pkg::NET_PC, main_pc_c * 4, '0);
   endtask

   //////////////////////////////
   // reference model
   //////////////////////////////

   // addressed and unicast, or broadcast by somebody else
   function automatic bit accepts(input pkt_t p);
      bit own;
      own = (p.ring_id == ring_id_c);
      return p.valid && !p.external && ((own && !p.bc) || (!own && p.bc));
   endfunction

   task automatic model_packet(input pkt_t p);
      if (accepts(p) && (p.op == tile_pkg::NET_INSTR))
      begin
         model_imem[p.addr[7:2]] = p.data;
      end
      else if (accepts(p) && (p.op == tile_pkg::NET_REG) && (p.addr[4:0] != 0))
      begin
         model_rf[p.addr[4:0]] = p.data;
      end
   endtask

   task automatic model_exec(input logic [31:0] ins);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  mask;
      int          off;
      bit          wr;
      a   = model_rf[ins[19:15]];
      b   = model_rf[ins[24:20]];
      wr  = 1'b0;
      res = '0;
      if ((ins[6:0] == `TILE_OP_IMM) && (ins[14:12] == 3'b000))
      begin
         res = a + {{20{ins[31]}}, ins[31:20]};
         wr  = 1'b1;
      end
      else if ((ins[6:0] == `TILE_OP_REG) && (ins[14:12] == 3'b000) &&
               ((ins[31:25] == 7'h00) || (ins[31:25] == 7'h20)))
      begin
         res = ins[30] ? a - b : a + b;
         wr  = 1'b1;
      end
      else if ((ins[6:0] == `TILE_OP_STORE) && (ins[14:12] <= 3'b010))
      begin
         addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
         off  = addr[1:0];
         mask = (ins[14:12] == 3'b000) ? 4'b0001 << off :
                (ins[14:12] == 3'b001) ? 4'b0011 << off : 4'b1111;
         data = '0;
         // lane i takes source byte i - off
         for (int i = 0; i < 4; i++)
         begin
            if (mask[i])
            begin
               data[8 * i +: 8] = b[8 * (i - off) +: 8];
            end
         end
         exp_q.push_back({addr, data, mask});
      end
      if (wr && (ins[11:7] != 0))
      begin
         model_rf[ins[11:7]] = res;
      end
   endtask

   task automatic model_walk(input int first, input int last);
      for (int w = first; w <= last; w++)
      begin
         model_exec(model_imem[w]);
      end
   endtask

   //////////////////////////////
   // drivers and checks
   //////////////////////////////

   task automatic drive_packet(input pkt_t p);
      @(posedge clk);
      net_valid_i    <= p.valid;
      net_ring_id_i  <= p.ring_id;
      net_external_i <= p.external;
      net_bc_i       <= p.bc;
      net_op_i       <= p.op;
      net_addr_i     <= p.addr;
      net_data_i     <= p.data;
   endtask

   task automatic apply_table();
      foreach (pkt_q[i])
      begin
         drive_packet(pkt_q[i]);
         model_packet(pkt_q[i]);
      end
      @(posedge clk);
      net_valid_i <= 1'b0;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // payload must sit still while valid waits for yumi
   task automatic check_held(input logic [67:0] held);
      assert (mem_valid_o)
      else
      begin
         $display("mem_valid_o dropped before the store was accepted");
         errors++;
      end
      check_value("mem_addr_o", mem_addr_o, held[67:36]);
      check_value("mem_data_o", mem_data_o, held[35:4]);
      check_value("mem_mask_o", {28'b0, mem_mask_o}, {28'b0, held[3:0]});
   endtask

   task automatic check_stores();
      logic [67:0] exp;
      logic [67:0] held;
      int          delay;
      int          n;
      while ((exp_q.size() > 0) && !timed_out)
      begin
         exp   = exp_q.pop_front();
         delay = $urandom % 6;
         @(negedge clk);
         n = 0;
         while (!mem_valid_o && (n < timeout_c))
         begin
            @(negedge clk);
            n++;
         end
         if (!mem_valid_o)
         begin
            $display("timeout: no store showed up within %0d cycles", timeout_c);
            errors++;
            timed_out = 1'b1;
            return;
         end
         held = {mem_addr_o, mem_data_o, mem_mask_o};
         repeat (delay)
         begin
            @(negedge clk);
            check_held(held);
         end
         @(posedge clk);
         mem_yumi_i <= 1'b1;
         @(negedge clk);
         check_held(exp);
         // accepted on this edge
         @(posedge clk);
         mem_yumi_i <= 1'b0;
      end
   endtask

   task automatic check_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         assert (!mem_valid_o)
         else
         begin
            $display("unexpected store at address %h", mem_addr_o);
            errors++;
         end
      end
   endtask

   task automatic end_test(input string name, input int mark);
      tests++;
      if (errors != mark)
      begin
         failed_tests++;
      end
      $display("test %-18s %s", name, (errors == mark) ? "ok" : "failed");
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      int   mark;
      pkt_t pc_pkt;
      errors         = 0;
      tests          = 0;
      failed_tests   = 0;
      timed_out      = 1'b0;
      reset          = 1'b1;
      net_valid_i    = 1'b0;
      net_ring_id_i  = '0;
      net_external_i = 1'b0;
      net_bc_i       = 1'b0;
      net_op_i       = tile_pkg::NET_NONE;
      net_addr_i     = '0;
      net_data_i     = '0;
      mem_yumi_i     = 1'b0;
      void'($urandom(32'h699));
      build_table();
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      // idle core never stores
      mark = errors;
      check_quiet(50);
      end_test("idle_after_reset", mark);

      // filter, arithmetic, lanes and random yumi in one program
      mark = errors;
      apply_table();
      model_walk(main_pc_c, 63);
      check_stores();
      end_test("load_and_run", mark);

      // pc packet while running points at the rerun program
      mark = errors;
      pc_pkt       = pkt_q[pkt_q.size() - 1];
      pc_pkt.addr  = alt_pc_c * 4;
      drive_packet(pc_pkt);
      @(posedge clk);
      net_valid_i <= 1'b0;
      check_quiet(quiet_c);
      end_test("pc_ignored_in_run", mark);

      // after reset the same packet starts the rerun program
      mark = errors;
      @(posedge clk);
      reset <= 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      check_quiet(4);
      drive_packet(pc_pkt);
      @(posedge clk);
      net_valid_i <= 1'b0;
      model_walk(alt_pc_c, main_pc_c - 1);
      check_stores();
      end_test("rerun_after_reset", mark);

      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if ((errors == 0) && !timed_out)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+hdl
hdl/tile_pkg.sv
hdl/net_priority_arb.sv
hdl/net_cmd_decoder.sv
hdl/imem.sv
hdl/regfile.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/tile_core.sv
test/tb_tile_core.sv

// File: Bender.yml
package:
  name: tile_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/tile_pkg.sv
      - hdl/net_priority_arb.sv
      - hdl/net_cmd_decoder.sv
      - hdl/imem.sv
      - hdl/regfile.sv
      - hdl/fetch_unit.sv
      - hdl/exec_unit.sv
      - hdl/tile_core.sv
  - target: test
    files:
      - test/tb_tile_core.sv
